// File: tb.f
hdl/trs_io_pkg.sv
hdl/cmd_if.sv
hdl/spi_slave.sv
hdl/cmd_parser.sv
hdl/io_port_decoder.sv
hdl/audio_channel.sv
hdl/trs_io_top.sv
sim/tb_trs_io.sv

// File: Bender.yml
package:
  name: trs_io

sources:
  - hdl/trs_io_pkg.sv
  - hdl/cmd_if.sv
  - hdl/spi_slave.sv
  - hdl/cmd_parser.sv
  - hdl/io_port_decoder.sv
  - hdl/audio_channel.sv
  - hdl/trs_io_top.sv
  - target: simulation
    files:
      - sim/tb_trs_io.sv

// File: sim/tb_trs_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trs_io;

  localparam int CLK_NS      = 4;
  localparam int HALF        = 8;  // clk cycles per sck half period
  localparam int N_CONF      = 4;
  localparam int N_LED       = 4;
  localparam int N_DBUS      = 4;
  localparam int N_DRDY      = 2;
  localparam int N_AUDIO     = 6;  // writes per orchestra mode
  localparam int SPI_BYTES   = 4 + 2 * N_CONF + 2 * N_LED + 2 * N_DBUS + N_DRDY;
  localparam int WATCHDOG_NS = SPI_BYTES * 16 * HALF * CLK_NS + 20000;

  // host opcodes
  localparam logic [7:0] OP_GET_COOKIE  = 8'd0;
  localparam logic [7:0] OP_DBUS_WRITE  = 8'd4;
  localparam logic [7:0] OP_DATA_READY  = 8'd5;
  localparam logic [7:0] OP_GET_VERSION = 8'd15;
  localparam logic [7:0] OP_SET_LED     = 8'd26;
  localparam logic [7:0] OP_GET_CONFIG  = 8'd27;
  localparam logic [7:0] DUMMY          = 8'hff;  // ignored by the parser

  typedef struct {
    string              name;
    logic signed [31:0] exp;
    logic signed [31:0] act;
    int                 tol;
  } check_t;

  logic              clk;
  logic              rst;
  logic              sck;
  logic              cs_n;
  logic              mosi;
  logic              miso;
  logic              io_in;
  logic              io_out;
  logic [7:0]        port;
  logic [7:0]        wr_data;
  logic [7:0]        rd_data;
  logic [3:0]        conf;
  logic              int_req;
  logic [2:0]        led;
  logic signed [8:0] audio_l;
  logic signed [8:0] audio_r;
  logic              pdm_l;
  logic              pdm_r;

  check_t check_q[$];
  int     n_pushed  = 0;
  int     n_checked = 0;
  int     n_errors  = 0;

  trs_io_top trs_io_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [7:0] exp_response(input logic [7:0] op, input logic [3:0] cfg);
    case (op)
      OP_GET_COOKIE:  return 8'haf;
      OP_GET_VERSION: return {3'd0, 5'd3};  // major 0, minor 3
      OP_GET_CONFIG:  return {4'h0, cfg};
      default:        return 8'h00;
    endcase
  endfunction

  // signed sample plus cassette term times 128
  function automatic int exp_mix(input logic [7:0] sample, input logic [1:0] cass);
    int s;
    int term;
    s    = $signed(sample);
    term = int'(!cass[1]) + int'(cass[0]) - 1;
    return s + term * 128;
  endfunction

  // conf[3] low selects the model iii port pair
  function automatic logic [7:0] orch_port(input logic m1, input int ch);
    if (m1) begin
      return (ch == 0) ? 8'hb5 : 8'hb9;
    end else begin
      return (ch == 0) ? 8'h75 : 8'h79;
    end
  endfunction

  function automatic void queue_check(input string name, input logic signed [31:0] exp,
                                      input logic signed [31:0] act, input int tol);
    check_t c;
    c.name = name;
    c.exp  = exp;
    c.act  = act;
    c.tol  = tol;
    check_q.push_back(c);
    n_pushed++;
  endfunction

  initial begin : compare_loop
    check_t             c;
    logic signed [31:0] diff;
    forever begin
      wait (check_q.size() != 0);
      c    = check_q.pop_front();
      diff = (c.act > c.exp) ? c.act - c.exp : c.exp - c.act;
      if ($isunknown(c.act) || diff > c.tol) begin
        n_errors++;
        $display("[ERROR] %s: expected %0h, got %0h", c.name, c.exp, c.act);
      end
      n_checked++;
    end
  end

  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("timeout: run still busy after %0d ns, %0d errors", WATCHDOG_NS, n_errors);
    $display("Test failed");
    $finish;
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;  // drive point
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    wait_clks(5);
    rst = 1'b0;
  endtask

  // one mode 0 byte with miso read at the end of each low half after a fall
  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    cs_n = 1'b0;
    for (int i = 7; i >= 0; i--) begin
      sck  = 1'b0;
      mosi = tx[i];
      wait_clks(HALF);
      if (i < 7) begin
        rx[i + 1] = miso;
      end
      sck = 1'b1;
      wait_clks(HALF);
    end
    sck = 1'b0;
    wait_clks(HALF);
    rx[0] = miso;
    cs_n  = 1'b1;
    mosi  = 1'b0;
    wait_clks(HALF);
  endtask

  task automatic z80_out(input logic [7:0] p, input logic [7:0] d);
    port    = p;
    wr_data = d;
    io_out  = 1'b1;
    wait_clks(1);
    io_out = 1'b0;
  endtask

  task automatic z80_in(input logic [7:0] p, output logic [7:0] d);
    port  = p;
    io_in = 1'b1;
    @(negedge clk);
    d = rd_data;
    wait_clks(1);
    io_in = 1'b0;
  endtask

  task automatic get_responses();
    logic [7:0] rx;
    spi_xfer(OP_GET_COOKIE, rx);
    spi_xfer(DUMMY, rx);
    queue_check("miso cookie", exp_response(OP_GET_COOKIE, conf), rx, 0);
    spi_xfer(OP_GET_VERSION, rx);
    spi_xfer(DUMMY, rx);
    queue_check("miso version", exp_response(OP_GET_VERSION, conf), rx, 0);
    for (int k = 0; k < N_CONF; k++) begin
      conf = 4'($urandom);
      spi_xfer(OP_GET_CONFIG, rx);
      spi_xfer(DUMMY, rx);
      queue_check("miso config", exp_response(OP_GET_CONFIG, conf), rx, 0);
    end
  endtask

  task automatic led_register();
    logic [7:0] p;
    logic [7:0] rx;
    for (int k = 0; k < N_LED; k++) begin
      p = 8'($urandom);
      spi_xfer(OP_SET_LED, rx);
      spi_xfer(p, rx);
      queue_check("led", p[2:0], led, 0);
    end
  endtask

  task automatic host_data_read();
    logic [7:0] b;
    logic [7:0] p;
    logic [7:0] rx;
    for (int k = 0; k < N_DBUS; k++) begin
      b = 8'($urandom);
      spi_xfer(OP_DBUS_WRITE, rx);
      spi_xfer(b, rx);
      z80_in(8'h1f, rx);
      queue_check("rd_data", b, rx, 0);
      do begin
        p = 8'($urandom);
      end while (p == 8'h1f);
      z80_in(p, rx);
      queue_check("rd_data other port", 0, rx, 0);
    end
  endtask

  task automatic data_ready_irq();
    logic [7:0] rx;
    for (int k = 0; k < N_DRDY; k++) begin
      queue_check("int_req idle", 0, int_req, 0);
      spi_xfer(OP_DATA_READY, rx);
      queue_check("int_req set", 1, int_req, 0);
      z80_in(8'h20 + 8'(k), rx);  // not the trs-io port
      queue_check("int_req kept", 1, int_req, 0);
      z80_in(8'h1f, rx);
      @(negedge clk);
      queue_check("int_req cleared", 0, int_req, 0);
      wait_clks(1);
    end
  endtask

  task automatic audio_mix();
    logic [7:0] l;
    logic [7:0] r;
    logic [7:0] c;
    for (int m = 0; m < 2; m++) begin
      conf[3] = m[0];
      for (int k = 0; k < N_AUDIO; k++) begin
        l = 8'($urandom);
        r = 8'($urandom);
        c = 8'($urandom);
        z80_out(orch_port(conf[3], 0), l);
        z80_out(orch_port(conf[3], 1), r);
        z80_out(8'hff, c);
        z80_out(orch_port(!conf[3], k % 2), 8'($urandom));  // other mode port has no effect
        wait_clks(3);
        @(negedge clk);
        queue_check("audio_l", exp_mix(l, c[1:0]), audio_l, 0);
        queue_check("audio_r", exp_mix(r, c[1:0]), audio_r, 0);
        wait_clks(1);
      end
    end
  endtask

  // ones density over 512 cycles follows the offset mix
  task automatic pdm_density();
    logic [7:0] l;
    logic [7:0] r;
    logic [7:0] c;
    int         ones_l;
    int         ones_r;
    apply_reset();
    @(negedge clk);
    queue_check("audio_l after reset", exp_mix(8'h00, 2'b00), audio_l, 0);
    queue_check("audio_r after reset", exp_mix(8'h00, 2'b00), audio_r, 0);
    wait_clks(1);
    l = 8'($urandom);
    r = 8'($urandom);
    c = 8'($urandom);
    z80_out(orch_port(conf[3], 0), l);
    z80_out(orch_port(conf[3], 1), r);
    z80_out(8'hff, c);
    wait_clks(3);
    ones_l = 0;
    ones_r = 0;
    repeat (512) begin
      @(negedge clk);
      ones_l += int'(pdm_l);
      ones_r += int'(pdm_r);
    end
    queue_check("pdm_l ones", exp_mix(l, c[1:0]) + 256, ones_l, 1);
    queue_check("pdm_r ones", exp_mix(r, c[1:0]) + 256, ones_r, 1);
  endtask

  initial begin
    rst     = 1'b1;
    sck     = 1'b0;
    cs_n    = 1'b1;
    mosi    = 1'b0;
    io_in   = 1'b0;
    io_out  = 1'b0;
    port    = 8'h00;
    wr_data = 8'h00;
    conf    = 4'h0;
    void'($urandom(80));
    apply_reset();
    get_responses();
    led_register();
    host_data_read();
    data_ready_irq();
    audio_mix();
    pdm_density();
    wait (n_checked == n_pushed);
    $display("checks: %0d, errors: %0d", n_checked, n_errors);
    if (n_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/trs_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module trs_io_top
  import trs_io_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    sck,
  input  logic                    cs_n,
  input  logic                    mosi,
  output logic                    miso,
  input  logic                    io_in,
  input  logic                    io_out,
  input  byte_t                   port,
  input  byte_t                   wr_data,
  output byte_t                   rd_data,
  input  logic [3:0]              conf,
  output logic                    int_req,
  output logic [2:0]              led,
  output logic signed [MIX_W-1:0] audio_l,
  output logic signed [MIX_W-1:0] audio_r,
  output logic                    pdm_l,
  output logic                    pdm_r
);

  byte_t                   rx_byte;
  logic                    rx_valid;
  byte_t                   tx_byte;
  logic [NUM_AUDIO_CH-1:0] orch_wr;
  byte_t                   orch_data;
  logic [1:0]              cass_level;
  logic signed [MIX_W-1:0] mix [NUM_AUDIO_CH];
  logic [NUM_AUDIO_CH-1:0] pdm;

  cmd_if host_cmd ();

  spi_slave spi_slave_i (
    .clk      (clk),
    .rst      (rst),
    .sck      (sck),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .tx_byte  (tx_byte)
  );

  cmd_parser cmd_parser_i (
    .clk      (clk),
    .rst      (rst),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .tx_byte  (tx_byte),
    .conf     (conf),
    .led      (led),
    .host     (host_cmd.parser)
  );

  io_port_decoder io_port_decoder_i (
    .clk        (clk),
    .rst        (rst),
    .io_in      (io_in),
    .io_out     (io_out),
    .port       (port),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .conf       (conf),
    .int_req    (int_req),
    .host       (host_cmd.port_block),
    .orch_wr    (orch_wr),
    .orch_data  (orch_data),
    .cass_level (cass_level)
  );

  // channel 0 left, channel 1 right
  for (genvar ch = 0; ch < NUM_AUDIO_CH; ch++) begin : g_audio
    audio_channel audio_channel_i (
      .clk         (clk),
      .rst         (rst),
      .sample_wr   (orch_wr[ch]),
      .sample_data (orch_data),
      .cass_level  (cass_level),
      .mix         (mix[ch]),
      .pdm         (pdm[ch])
    );
  end

  assign audio_l = mix[0];
  assign audio_r = mix[1];
  assign pdm_l   = pdm[0];
  assign pdm_r   = pdm[1];

endmodule

`default_nettype wire

// File: hdl/audio_channel.sv
`timescale 1ns/1ps
`default_nettype none

module audio_channel
  import trs_io_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    sample_wr,
  input  byte_t                   sample_data,
  input  logic [1:0]              cass_level,
  output logic signed [MIX_W-1:0] mix,
  output logic                    pdm
);

  logic signed [7:0]     sample;    // orchestra byte, two's complement
  logic signed [1:0]     cass_term; // -1, 0 or +1
  logic signed [MIX_W:0] mix_wide;  // one spare bit for the overflow check
  logic [MIX_W:0]        acc;

  always_ff @(posedge clk) begin
    if (rst) begin
      sample <= '0;
    end else if (sample_wr) begin
      sample <= sample_data;
    end
  end

  // inverted bit 1 plus bit 0, less one
  assign cass_term = {1'b0, ~cass_level[1]} + {1'b0, cass_level[0]} - 2'd1;

  assign mix_wide = {{(MIX_W + 1 - 8){sample[7]}}, sample}
                  + {cass_term[1], cass_term, 7'b0000000};
  assign mix      = mix_wide[MIX_W-1:0];

  // first order sigma-delta, carry out is the bit stream
  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else begin
      acc <= {1'b0, acc[MIX_W-1:0]} + {1'b0, ~mix[MIX_W-1], mix[MIX_W-2:0]};
    end
  end

  assign pdm = acc[MIX_W];

  a_mix_no_wrap: assert property (
    @(posedge clk) disable iff (rst) mix_wide[MIX_W] == mix_wide[MIX_W-1]
  );

endmodule

`default_nettype wire

// File: hdl/io_port_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module io_port_decoder
  import trs_io_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    io_in,
  input  logic                    io_out,
  input  byte_t                   port,
  input  byte_t                   wr_data,
  output byte_t                   rd_data,
  input  logic [3:0]              conf,
  output logic                    int_req,
  cmd_if.port_block               host,
  output logic [NUM_AUDIO_CH-1:0] orch_wr,
  output byte_t                   orch_data,
  output logic [1:0]              cass_level
);

  logic                    is_m3;
  logic                    trs_io_rd;
  logic                    cass_wr;
  logic                    data_ready_flag;
  byte_t                   host_data;  // byte from dbus_write
  logic [NUM_AUDIO_CH-1:0] orch_sel;

  assign is_m3     = ~conf[3];  // jumper low means model iii
  assign trs_io_rd = io_in && (port == TRS_IO_PORT);
  assign cass_wr   = io_out && (port == CASS_PORT);

  // orchestra-85 or orchestra-90 address set
  always_comb begin
    for (int ch = 0; ch < NUM_AUDIO_CH; ch++) begin
      orch_sel[ch] = io_out && (port == (is_m3 ? ORCH_M3_PORT[ch] : ORCH_M1_PORT[ch]));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_ready_flag <= 1'b0;
      cass_level      <= '0;
      orch_wr         <= '0;
    end else begin
      orch_wr <= orch_sel;
      if (cass_wr) begin
        cass_level <= wr_data[1:0];
      end
      if (trs_io_rd) begin
        data_ready_flag <= 1'b0;  // z80 picked up the byte
      end
      // a new data_ready from the host wins over the clear
      if (host.trigger && host.cmd == data_ready) begin
        data_ready_flag <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (host.trigger && host.cmd == dbus_write) begin
      host_data <= host.param0;
    end
    if (|orch_sel) begin
      orch_data <= wr_data;
    end
  end

  assign int_req = data_ready_flag;
  assign rd_data = trs_io_rd ? host_data : '0;

endmodule

`default_nettype wire

// File: hdl/cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_parser
  import trs_io_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  byte_t      rx_byte,
  input  logic       rx_valid,
  output byte_t      tx_byte,
  input  logic [3:0] conf,
  output logic [2:0] led,
  cmd_if.parser      host
);

  localparam int CNT_W = $clog2(MAX_PARAMS + 1);
  localparam int IDX_W = (MAX_PARAMS > 1) ? $clog2(MAX_PARAMS) : 1;

  parser_state_e    state;
  logic [CNT_W-1:0] remaining;  // parameter bytes still to come
  logic [IDX_W-1:0] idx;
  logic             trigger;
  spi_cmd_e         cmd;
  byte_t            params [MAX_PARAMS];

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      remaining <= '0;
      idx       <= '0;
      trigger   <= 1'b0;
      tx_byte   <= '0;
    end else begin
      trigger <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            idx <= '0;
            case (rx_byte)
              get_cookie: begin
                trigger <= 1'b1;
                tx_byte <= COOKIE;
              end
              get_version: begin
                trigger <= 1'b1;
                tx_byte <= {VERSION_MAJOR, VERSION_MINOR};
              end
              get_config: begin
                trigger <= 1'b1;
                tx_byte <= {4'b0000, conf};
              end
              data_ready: trigger <= 1'b1;
              dbus_write, set_led: begin
                remaining <= CNT_W'(1);
                state     <= read_bytes;
              end
              default: ;  // unknown opcode, stay idle
            endcase
          end
          read_bytes: begin
            idx <= idx + IDX_W'(1);
            if (remaining == CNT_W'(1)) begin
              trigger <= 1'b1;
              state   <= idle;
            end else begin
              remaining <= remaining - CNT_W'(1);
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && state == idle) begin
      cmd <= spi_cmd_e'(rx_byte);
    end
    if (rx_valid && state == read_bytes) begin
      params[idx] <= rx_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      led <= '0;
    end else if (trigger && cmd == set_led) begin
      led <= params[0][2:0];  // red, green, blue
    end
  end

  assign host.trigger = trigger;
  assign host.cmd     = cmd;
  assign host.param0  = params[0];
  assign host.param1  = params[1];

  a_count_in_read: assert property (
    @(posedge clk) disable iff (rst) state == read_bytes |-> remaining != '0
  );

endmodule

`default_nettype wire

// File: hdl/spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  mosi,
  output logic  miso,
  output byte_t rx_byte,
  output logic  rx_valid,
  input  byte_t tx_byte
);

  logic [2:0] sck_sync;  // two sync stages plus one for edge detect
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  byte_t      rx_shift;
  byte_t      tx_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync  <= '0;
      cs_sync   <= 2'b11;  // deselected
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      tx_shift <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;  // drop any partial byte
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            rx_valid <= 1'b1;
          end
        end
        // response is picked up after the first bit of a byte
        if (sck_fall) begin
          if (bit_cnt == 3'd1) begin
            tx_shift <= tx_byte;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};  // msb first
    end
  end

  assign rx_byte = rx_shift;
  assign miso    = cs_active ? tx_shift[7] : 1'b0;

  // the host still selects the slave when a byte completes
  a_rx_only_selected: assert property (
    @(posedge clk) disable iff (rst) rx_valid |-> cs_active
  );

endmodule

`default_nettype wire

// File: hdl/cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// one executed host command, valid only while trigger is high
interface cmd_if
  import trs_io_pkg::*;
();

  logic     trigger;  // single cycle pulse
  spi_cmd_e cmd;
  byte_t    param0;
  byte_t    param1;

  modport parser (
    output trigger,
    output cmd,
    output param0,
    output param1
  );

  modport port_block (
    input trigger,
    input cmd,
    input param0,
    input param1
  );

endinterface

`default_nettype wire

// File: hdl/trs_io_pkg.sv
`default_nettype none

package trs_io_pkg;

  typedef logic [7:0] byte_t;

  // opcodes sent by the network processor
  typedef enum logic [7:0] {
    get_cookie  = 8'd0,
    dbus_write  = 8'd4,
    data_ready  = 8'd5,
    get_version = 8'd15,
    set_led     = 8'd26,
    get_config  = 8'd27
  } spi_cmd_e;

  typedef enum logic [1:0] {
    idle       = 2'd0,
    read_bytes = 2'd1  // collecting parameter bytes
  } parser_state_e;

  // identity returned to the host
  localparam byte_t COOKIE = 8'haf;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  localparam int MAX_PARAMS = 2;  // parameter buffer depth

  // z80 i/o ports
  localparam byte_t TRS_IO_PORT = 8'h1f;
  localparam byte_t CASS_PORT   = 8'hff;

  localparam int NUM_AUDIO_CH = 2;
  localparam int MIX_W        = 9;  // signed mixed sample width

  // orchestra ports, index 0 left and 1 right
  localparam logic [NUM_AUDIO_CH-1:0][7:0] ORCH_M1_PORT = {8'hb9, 8'hb5};  // orchestra-85
  localparam logic [NUM_AUDIO_CH-1:0][7:0] ORCH_M3_PORT = {8'h79, 8'h75};  // orchestra-90

endpackage

`default_nettype wire
